//--- source/opdec_defs.svh
/*
 * global sizes for the opcode decryption unit
 * word address width, key table address width, fetch queue depth
 */
`ifndef OPDEC_DEFS_SVH
`define OPDEC_DEFS_SVH

// CPU address bits 23:1
`define OPDEC_ADDR_W 23

// 8K entry main key table
`define OPDEC_KEY_AW 13

`define OPDEC_QUEUE_DEPTH 4

`endif

//--- source/cipher_pkg.sv
/*
 * cipher types
 * state byte, global key byte, main key byte, key table address
 */
`default_nettype none

`include "opdec_defs.svh"

package cipher_pkg;

    // rewritten by the CPU, here it arrives with every fetch
    typedef logic [7:0] state_t;

    typedef logic [7:0] gkey_t; // three per chip
    typedef logic [7:0] mkey_t; // one per table entry

    // also used as the programming address
    typedef logic [`OPDEC_KEY_AW-1:0] key_addr_t;

endpackage

`default_nettype wire

//--- source/fetch_pkg.sv
/*
 * bus types of the fetch path
 * word address and 16 bit code word
 */
`default_nettype none

`include "opdec_defs.svh"

package fetch_pkg;

    typedef logic [`OPDEC_ADDR_W-1:0] waddr_t;

    // encrypted and plain words alike
    typedef logic [15:0] code_t;

endpackage

`default_nettype wire

//--- source/fetch_port.sv
/*
 * fetch_port
 * four-phase slave on the fetch side, one queue push per request
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_port (
    input  logic clk,
    input  logic arst_n,
    input  logic fetch_req,
    output logic fetch_ack,
    input  logic full,
    output logic push
);

    logic ack_q;

    // accept only a fresh request, queue full holds it off
    assign push      = fetch_req & ~ack_q & ~full;
    assign fetch_ack = ack_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q <= 1'b0;
        end else if (push) begin
            ack_q <= 1'b1;           // ack the cycle after the push
        end else if (!fetch_req) begin
            ack_q <= 1'b0;           // master released, close the cycle
        end
    end

endmodule

`default_nettype wire

//--- source/fetch_queue.sv
/*
 * fetch_queue
 * circular FIFO of pending fetches: address, encrypted word, state, vector flag
 */
`timescale 1ns/1ps
`default_nettype none

`include "opdec_defs.svh"

module fetch_queue (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               push,
    input  fetch_pkg::waddr_t  in_addr,
    input  fetch_pkg::code_t   in_enc,
    input  cipher_pkg::state_t in_st,
    input  logic               in_vrq,
    output logic               full,
    input  logic               pop,
    output logic               empty,
    output fetch_pkg::waddr_t  head_addr,
    output fetch_pkg::code_t   head_enc,
    output cipher_pkg::state_t head_st,
    output logic               head_vrq
);

    localparam int DEPTH = `OPDEC_QUEUE_DEPTH;
    localparam int PW    = $clog2(DEPTH);

    fetch_pkg::waddr_t  addr_mem [DEPTH];
    fetch_pkg::code_t   enc_mem  [DEPTH];
    cipher_pkg::state_t st_mem   [DEPTH];
    logic               vrq_mem  [DEPTH];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign full    = (count == (PW+1)'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // head is valid while not empty
    assign head_addr = addr_mem[rd_ptr];
    assign head_enc  = enc_mem[rd_ptr];
    assign head_st   = st_mem[rd_ptr];
    assign head_vrq  = vrq_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            addr_mem[wr_ptr] <= in_addr;
            enc_mem[wr_ptr]  <= in_enc;
            st_mem[wr_ptr]   <= in_st;
            vrq_mem[wr_ptr]  <= in_vrq;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == PW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= (rd_ptr == PW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            count <= count + {{PW{1'b0}}, do_push} - {{PW{1'b0}}, do_pop};
        end
    end

endmodule

`default_nettype wire

//--- source/key_table.sv
/*
 * key_table
 * main key RAM, 8K bytes, registered read
 */
`timescale 1ns/1ps
`default_nettype none

`include "opdec_defs.svh"

module key_table (
    input  logic                  clk,
    input  logic                  we,
    input  cipher_pkg::key_addr_t wr_addr,
    input  cipher_pkg::mkey_t     wr_data,
    input  cipher_pkg::key_addr_t rd_addr,
    output cipher_pkg::mkey_t     rd_data
);

    cipher_pkg::mkey_t mem [1 << `OPDEC_KEY_AW];

    always_ff @(posedge clk) begin
        if (we) mem[wr_addr] <= wr_data;
        rd_data <= mem[rd_addr];    // one cycle read
    end

endmodule

`default_nettype wire

//--- source/cipher_core.sv
/*
 * cipher_core
 * global key registers, main key lookup and the two stage opcode decrypt pipeline
 */
`timescale 1ns/1ps
`default_nettype none

`include "opdec_defs.svh"

module cipher_core (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  prog_we,
    input  cipher_pkg::key_addr_t prog_addr,
    input  cipher_pkg::mkey_t     prog_data,
    input  logic                  in_valid,
    input  fetch_pkg::waddr_t     in_addr,
    input  fetch_pkg::code_t      in_enc,
    input  cipher_pkg::state_t    in_st,
    input  logic                  in_vrq,
    output logic                  dec_valid,
    output fetch_pkg::code_t      dec_word
);

    // map holds 16 source bit indices as nibbles, msb first
    function automatic fetch_pkg::code_t bitswap(input fetch_pkg::code_t v,
                                                 input logic [63:0] map);
        fetch_pkg::code_t r;
        for (int i = 0; i < 16; i++) begin
            r[i] = v[map[4*i +: 4]];
        end
        return r;
    endfunction

    cipher_pkg::gkey_t     gkey1, gkey2, gkey3;
    cipher_pkg::gkey_t     gk1_st, gk2_st, gk3_st;
    cipher_pkg::key_addr_t key_low;
    cipher_pkg::key_addr_t key_rd_addr;
    cipher_pkg::mkey_t     mainkey;

    logic               s1_valid;
    fetch_pkg::waddr_t  s1_addr;
    fetch_pkg::code_t   s1_enc;
    cipher_pkg::state_t s1_st;
    logic               s1_vrq;
    fetch_pkg::code_t   val;

    logic g_xor0, g_xor1, g_swap0a, g_swap0b, g_swap1, g_swap2, g_swap3, g_swap4;
    logic key_0a, key_0b, key_0c, key_1a, key_1b, key_2a, key_2b, key_3a, key_3b;
    logic key_4a, key_4b, key_5a, key_5b, key_6a, key_6b, key_7a;

    // global keys live at programming addresses 0..2
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gkey1 <= '0;
            gkey2 <= '0;
            gkey3 <= '0;
        end else if (prog_we) begin
            if (prog_addr == 'd0) gkey1 <= prog_data;
            if (prog_addr == 'd1) gkey2 <= prog_data;
            if (prog_addr == 'd2) gkey3 <= prog_data;
        end
    end

    // stage 1: table address, words 4 and 5 use the upper half
    always_comb begin
        key_low     = in_addr[`OPDEC_KEY_AW-1:0];
        key_rd_addr = key_low;
        if (key_low == 'd4 || key_low == 'd5) key_rd_addr[`OPDEC_KEY_AW-1] = 1'b1;
    end

    key_table u_key_table (
        .clk     (clk),
        .we      (prog_we),
        .wr_addr (prog_addr),
        .wr_data (prog_data),
        .rd_addr (key_rd_addr),
        .rd_data (mainkey)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) s1_valid <= 1'b0;
        else         s1_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        s1_addr <= in_addr;
        s1_enc  <= in_enc;
        s1_st   <= in_st;
        s1_vrq  <= in_vrq;
    end

    // stage 2: fold state into the global keys
    always_comb begin
        gk1_st = gkey1 ^ {s1_st[2], s1_st[4], s1_st[3], s1_st[6],
                          s1_st[5], s1_st[0], s1_st[4], s1_st[1]};
        gk2_st = gkey2 ^ {s1_st[0], s1_st[2], s1_st[6], s1_st[1],
                          s1_st[4], s1_st[6], s1_st[3], s1_st[7]};
        gk3_st = gkey3 ^ {s1_st[0], s1_st[7], s1_st[3], s1_st[5],
                          s1_st[5], s1_st[2], s1_st[7], s1_st[1]};
        if (s1_vrq) begin               // reset/interrupt vector fetch
            if (s1_addr <= 'd3) gk3_st = '0;
            if (s1_addr <= 'd2) gk2_st = '0;
            if (s1_addr <= 'd1) gk1_st = '0;
        end
    end

    assign g_xor0   = ~gk1_st[5];
    assign g_xor1   = ~gk1_st[2];
    assign g_swap2  = ~gk1_st[0];
    assign g_swap0a = ~gk2_st[5];
    assign g_swap0b = ~gk2_st[2];
    assign g_swap3  = ~gk3_st[6];
    assign g_swap1  = ~gk3_st[4];
    assign g_swap4  = ~gk3_st[2];

    assign key_0a = mainkey[0] ^ gk3_st[1];
    assign key_0b = mainkey[0] ^ gk1_st[7];
    assign key_0c = mainkey[0] ^ gk1_st[1];
    assign key_1a = mainkey[1] ^ gk2_st[7];
    assign key_1b = mainkey[1] ^ gk1_st[3];
    assign key_2a = mainkey[2] ^ gk3_st[7];
    assign key_2b = mainkey[2] ^ gk1_st[4];
    assign key_3a = mainkey[3] ^ gk2_st[0];
    assign key_3b = mainkey[3] ^ gk3_st[3];
    assign key_4a = mainkey[4] ^ gk2_st[3];
    assign key_4b = mainkey[4] ^ gk3_st[0];
    assign key_5a = mainkey[5] ^ gk3_st[5];
    assign key_5b = mainkey[5] ^ gk1_st[6];
    assign key_6a = mainkey[6] ^ gk2_st[1];
    assign key_6b = mainkey[6] ^ gk2_st[6];
    assign key_7a = mainkey[7] ^ gk2_st[4];

    // conditional rounds, each entered on its own top bit
    always_comb begin
        val = s1_enc;
        if (val[15]) begin
            val = bitswap(val, 64'hF9AD_3C0E_652B_8147);
            if (!g_xor1 && !val[11]) val ^= 16'h3002;
            if (!val[5]) val ^= 16'h0044;
            if (!key_1b && !val[10]) val ^= 16'h0890;
            if (!g_swap2 && !key_0c) val ^= 16'h0308;
            val ^= 16'h6561;
            if (!key_2b) val = bitswap(val, 64'hFADC_BE98_7604_3215);
        end
        if (val[14]) begin
            val = bitswap(val, 64'hDE70_8642_1F3B_CA59);
            if (!g_xor0 && val[4]) val ^= 16'h0468;
            if (!key_3a && val[8]) val ^= 16'h0081;
            if (!key_6a && val[2]) val ^= 16'h0100;
            if (!key_5b && !key_0b) val ^= 16'h3012;
            val ^= 16'h3523;
            if (!g_swap0b) val = bitswap(val, 64'h2EDC_9AB8_7654_3F10);
        end
        if (val[13]) begin
            val = bitswap(val, 64'hA2D7_803E_6F1B_945C);
            if (!key_4a && val[11]) val ^= 16'h010C;
            if (!key_1a && val[7]) val ^= 16'h1000;
            if (!key_7a && val[10]) val ^= 16'h0A21;
            if (!key_4b && !key_0a) val ^= 16'h0080;
            if (!g_swap0a && !key_6b) val ^= 16'hC000;
            val ^= 16'h99A5;
            if (!key_5b) val = bitswap(val, 64'hFEDC_B198_7A56_3240);
        end
        if (val[15:13] != 3'b000) begin     // fourth round, swaps only
            val = bitswap(val, 64'hFDE5_609A_4B12_C378);
            val ^= 16'h17FF;
            if (!g_swap4)  val = bitswap(val, 64'hFED6_BA95_7C84_3210);
            if (!g_swap3)  val = bitswap(val, 64'hDFEC_BA98_7654_3210);
            if (!g_swap2)  val = bitswap(val, 64'hFEDC_B298_A654_3017);
            if (!key_3b)   val = bitswap(val, 64'hFEDC_BA48_7659_1230);
            if (!key_2a)   val = bitswap(val, 64'hDEFC_BA98_7654_3210);
            if (!g_swap1)  val = bitswap(val, 64'hFEDC_98BA_7654_3210);
            if (!key_5a)   val = bitswap(val, 64'hFEDC_BA98_4576_3210);
            if (!g_swap0a) val = bitswap(val, 64'hFEDC_BA98_7654_0321);
        end
        // bit 12 moves up, then opcode fixups
        val = bitswap(val, 64'hCFED_BA98_7654_3210);
        if ((val & 16'hB080) == 16'h8000) val ^= 16'h4000;
        if ((val & 16'hF000) == 16'hC000) val ^= 16'h0080;
        if ((val & 16'hB100) == 16'h0000) val ^= 16'h4000;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) dec_valid <= 1'b0;
        else         dec_valid <= s1_valid;
    end

    always_ff @(posedge clk) begin
        if (s1_valid) dec_word <= val;
    end

endmodule

`default_nettype wire

//--- source/result_port.sv
/*
 * result_port
 * credit based queue consumer, 2 entry result buffer, four-phase output master
 */
`timescale 1ns/1ps
`default_nettype none

module result_port (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             empty,
    output logic             pop,
    input  logic             dec_valid,
    input  fetch_pkg::code_t dec_word,
    output logic             out_req,
    output fetch_pkg::code_t out_word,
    input  logic             out_ack
);

    fetch_pkg::code_t buf_mem [2];

    logic [1:0] inflight;    // popped, not yet decoded
    logic [1:0] buf_count;
    logic [2:0] credit_used;
    logic       buf_wr;
    logic       buf_rd;
    logic       present;
    logic       done;

    assign credit_used = {1'b0, inflight} + {1'b0, buf_count};
    assign pop         = ~empty & (credit_used < 3'd2);

    // next word only once the previous ack is gone
    assign present = ~out_req & ~out_ack & (buf_count != 2'd0);
    assign done    = out_req & out_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inflight  <= '0;
            buf_count <= '0;
            buf_wr    <= 1'b0;
            buf_rd    <= 1'b0;
            out_req   <= 1'b0;
        end else begin
            inflight  <= inflight + {1'b0, pop} - {1'b0, dec_valid};
            buf_count <= buf_count + {1'b0, dec_valid} - {1'b0, done};
            if (dec_valid) buf_wr <= ~buf_wr;
            if (done) begin
                out_req <= 1'b0;
                buf_rd  <= ~buf_rd;  // word delivered, free its slot
            end else if (present) begin
                out_req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) buf_mem[buf_wr] <= dec_word;
        if (present)   out_word <= buf_mem[buf_rd];  // stable through the handshake
    end

endmodule

`default_nettype wire

//--- source/opdec_top.sv
/*
 * opdec_top
 * fetch port, fetch queue, cipher core and result port
 */
`timescale 1ns/1ps
`default_nettype none

module opdec_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  prog_we,
    input  cipher_pkg::key_addr_t prog_addr,
    input  cipher_pkg::mkey_t     prog_data,
    input  logic                  fetch_req,
    input  fetch_pkg::waddr_t     fetch_addr,
    input  fetch_pkg::code_t      fetch_enc,
    input  cipher_pkg::state_t    fetch_st,
    input  logic                  fetch_vrq,
    output logic                  fetch_ack,
    output logic                  out_req,
    output fetch_pkg::code_t      out_word,
    input  logic                  out_ack
);

    logic               push, full, pop, empty, head_vrq, dec_valid;
    fetch_pkg::waddr_t  head_addr;
    fetch_pkg::code_t   head_enc, dec_word;
    cipher_pkg::state_t head_st;

    fetch_port u_fetch_port (
        .clk (clk), .arst_n (arst_n), .fetch_req (fetch_req), .fetch_ack (fetch_ack),
        .full (full), .push (push)
    );

    fetch_queue u_fetch_queue (
        .clk (clk), .arst_n (arst_n), .push (push), .in_addr (fetch_addr),
        .in_enc (fetch_enc), .in_st (fetch_st), .in_vrq (fetch_vrq), .full (full),
        .pop (pop), .empty (empty), .head_addr (head_addr), .head_enc (head_enc),
        .head_st (head_st), .head_vrq (head_vrq)
    );

    // head fields feed the core directly, pop marks them valid
    cipher_core u_cipher_core (
        .clk (clk), .arst_n (arst_n), .prog_we (prog_we), .prog_addr (prog_addr),
        .prog_data (prog_data), .in_valid (pop), .in_addr (head_addr),
        .in_enc (head_enc), .in_st (head_st), .in_vrq (head_vrq),
        .dec_valid (dec_valid), .dec_word (dec_word)
    );

    result_port u_result_port (
        .clk (clk), .arst_n (arst_n), .empty (empty), .pop (pop),
        .dec_valid (dec_valid), .dec_word (dec_word), .out_req (out_req),
        .out_word (out_word), .out_ack (out_ack)
    );

endmodule

`default_nettype wire

//--- sim/opdec_tb.sv
/*
 * testbench for opdec_top
 * clock and reset, key table loading, fetch stimulus, output receiver
 * and the pass-through reference rule
 */
`timescale 1ns/1ps
`default_nettype none

module opdec_tb;

    localparam logic [31:0] SEED  = 32'h030c_fa59;
    localparam int          LIMIT = 200;    // cycles per wait loop

    logic                  clk;
    logic                  arst_n;
    logic                  prog_we;
    cipher_pkg::key_addr_t prog_addr;
    cipher_pkg::mkey_t     prog_data;
    logic                  fetch_req;
    fetch_pkg::waddr_t     fetch_addr;
    fetch_pkg::code_t      fetch_enc;
    cipher_pkg::state_t    fetch_st;
    logic                  fetch_vrq;
    logic                  fetch_ack;
    logic                  out_req;
    fetch_pkg::code_t      out_word;
    logic                  out_ack;

    logic [31:0]      rng;
    logic [31:0]      rx_rng;
    logic             hold_ack;     // receiver withholds out_ack
    int               errors;
    int               timeouts;
    int               n_sent;
    int               n_out;
    fetch_pkg::code_t exp_q[$];
    logic             any_q[$];     // set when the word is only captured
    fetch_pkg::code_t captured[$];
    fetch_pkg::code_t expv;
    logic             anyv;

    opdec_top dut (
        .clk (clk), .arst_n (arst_n), .prog_we (prog_we), .prog_addr (prog_addr),
        .prog_data (prog_data), .fetch_req (fetch_req), .fetch_addr (fetch_addr),
        .fetch_enc (fetch_enc), .fetch_st (fetch_st), .fetch_vrq (fetch_vrq),
        .fetch_ack (fetch_ack), .out_req (out_req), .out_word (out_word), .out_ack (out_ack)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // words with bits 15:13 clear skip every keyed round
    function automatic fetch_pkg::code_t expect_passthrough(input fetch_pkg::code_t enc);
        fetch_pkg::code_t v;
        v        = enc;
        v[15]    = enc[12];
        v[13:12] = 2'b00;
        // fixups reduced to the pass-through case
        if (enc[12]) begin
            v[14] = ~enc[7];
            v[7]  = 1'b1;
        end else begin
            v[14] = ~enc[8];
        end
        return v;
    endfunction

    task automatic raise_req(input fetch_pkg::waddr_t a, input fetch_pkg::code_t e,
                             input cipher_pkg::state_t s, input logic v);
        fetch_addr = a;
        fetch_enc  = e;
        fetch_st   = s;
        fetch_vrq  = v;
        fetch_req  = 1'b1;
    endtask

    task automatic wait_ack(input int limit, output logic ok);
        int t;
        t = 0;
        while (!fetch_ack && t < limit) begin
            @(posedge clk);
            #1;
            t++;
        end
        ok = fetch_ack;
    endtask

    task automatic drop_req;
        int t;
        fetch_req = 1'b0;
        t = 0;
        while (fetch_ack && t < LIMIT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (fetch_ack) begin
            timeouts++;
            $display("timeout: fetch_ack stayed high after fetch_req dropped");
        end
    endtask

    task automatic record(input fetch_pkg::code_t e, input logic capture);
        exp_q.push_back(e);
        any_q.push_back(capture);
        n_sent++;
    endtask

    task automatic send_fetch(input fetch_pkg::waddr_t a, input fetch_pkg::code_t e,
                              input cipher_pkg::state_t s, input logic v,
                              input fetch_pkg::code_t e_out, input logic capture);
        logic ok;
        raise_req(a, e, s, v);
        wait_ack(LIMIT, ok);
        if (ok) begin
            record(e_out, capture);
        end else begin
            timeouts++;
            $display("timeout: fetch_ack never rose for a fetch");
        end
        drop_req();
    endtask

    task automatic send_passthrough(input fetch_pkg::code_t enc);
        fetch_pkg::waddr_t a;
        rng = xorshift(rng);
        a   = rng[31:9];
        if (rng[0]) a = {20'd0, rng[3:1]};     // vector override range
        rng = xorshift(rng);
        send_fetch(a, enc, rng[7:0], rng[8], expect_passthrough(enc), 1'b0);
    endtask

    task automatic drain;
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < 4 * LIMIT) begin
            @(posedge clk);
            #1;
            t++;
        end
        if (exp_q.size() != 0) begin
            timeouts++;
            $display("timeout: %0d results never came out", exp_q.size());
        end
        repeat (10) @(posedge clk);
        #1;
        assert (n_out == n_sent) else begin
            errors++;
            $display("error at %0t: %0d fetches accepted, %0d words out", $time, n_sent, n_out);
        end
    endtask

    // receiver with random ack delay checks each word as it is taken
    initial begin
        out_ack = 1'b0;
        rx_rng  = {SEED[15:0], SEED[31:16]};
        forever begin
            @(posedge clk);
            #1;
            if (out_req && !out_ack && !hold_ack) begin
                rx_rng = xorshift(rx_rng);
                if (rx_rng[1:0] != 2'd0) begin
                    assert (exp_q.size() != 0) else begin
                        errors++;
                        $display("error at %0t: word %h with no fetch pending", $time, out_word);
                    end
                    if (exp_q.size() != 0) begin
                        expv = exp_q.pop_front();
                        anyv = any_q.pop_front();
                        if (anyv) begin
                            captured.push_back(out_word);
                        end else begin
                            assert (out_word == expv) else begin
                                errors++;
                                $display("error at %0t: got %h, expected %h",
                                         $time, out_word, expv);
                            end
                        end
                    end
                    n_out++;
                    out_ack = 1'b1;
                end
            end else if (!out_req && out_ack) begin
                out_ack = 1'b0;
            end
        end
    end

    initial begin
        int k;
        logic ok;
        fetch_pkg::code_t enc;
        fetch_pkg::waddr_t a;
        clk = 1'b0;
        arst_n = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        fetch_req = 1'b0;
        fetch_addr = '0;
        fetch_enc = '0;
        fetch_st = '0;
        fetch_vrq = 1'b0;
        hold_ack = 1'b0;
        rng = SEED;
        errors = 0;
        timeouts = 0;
        n_sent = 0;
        n_out = 0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        for (k = 0; k < 10; k++) begin      // quiet after reset
            assert (!out_req && !fetch_ack) else begin
                errors++;
                $display("error at %0t: handshake active before any request", $time);
            end
            @(posedge clk);
            #1;
        end
        for (k = 0; k < 8192; k++) begin    // whole key table including the global keys
            rng = xorshift(rng);
            prog_we = 1'b1;
            prog_addr = 13'(k);
            prog_data = rng[7:0];
            @(posedge clk);
            #1;
        end
        prog_we = 1'b0;
        for (k = 0; k < 40; k++) begin
            rng = xorshift(rng);
            send_passthrough({3'b000, rng[12:0]});
        end
        for (k = 0; k < 16; k++) begin      // distinct low nibble keeps words apart
            rng = xorshift(rng);
            send_passthrough({3'b000, rng[12:4], 4'(k)});
        end
        drain();
        hold_ack = 1'b1;                    // 4 queue entries plus 2 result slots
        for (k = 0; k < 6; k++) begin
            rng = xorshift(rng);
            send_passthrough({3'b000, rng[12:0]});
        end
        rng = xorshift(rng);
        enc = {3'b000, rng[12:0]};
        raise_req(rng[31:9], enc, rng[7:0], 1'b0);
        wait_ack(20, ok);
        assert (!ok) else begin
            errors++;
            $display("error at %0t: fetch_ack rose while the output was stalled", $time);
        end
        hold_ack = 1'b0;
        wait_ack(LIMIT, ok);
        if (ok) begin
            record(expect_passthrough(enc), 1'b0);
        end else begin
            timeouts++;
            $display("timeout: stalled fetch was never accepted after release");
        end
        drop_req();
        drain();
        for (k = 0; k < 3; k++) begin       // new global keys
            rng = xorshift(rng);
            prog_we = 1'b1;
            prog_addr = 13'(k);
            prog_data = rng[7:0];
            @(posedge clk);
            #1;
        end
        prog_we = 1'b0;
        for (k = 0; k < 20; k++) begin
            rng = xorshift(rng);
            send_passthrough({3'b000, rng[12:0]});
        end
        for (k = 0; k < 8; k++) begin       // same fetch twice for any word class
            rng = xorshift(rng);
            enc = rng[15:0];
            a = rng[31:9];
            rng = xorshift(rng);
            send_fetch(a, enc, rng[7:0], rng[8], '0, 1'b1);
            send_fetch(a, enc, rng[7:0], rng[8], '0, 1'b1);
        end
        drain();
        assert (captured.size() == 16) else begin
            errors++;
            $display("error at %0t: %0d repeated words captured", $time, captured.size());
        end
        for (k = 0; k + 1 < captured.size(); k += 2) begin
            assert (captured[k] == captured[k+1]) else begin
                errors++;
                $display("error at %0t: repeat gave %h then %h",
                         $time, captured[k], captured[k+1]);
            end
        end
        $display("%0d fetches, %0d value errors, %0d timeouts", n_sent, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+source
source/cipher_pkg.sv
source/fetch_pkg.sv
source/fetch_port.sv
source/fetch_queue.sv
source/key_table.sv
source/cipher_core.sv
source/result_port.sv
source/opdec_top.sv
sim/opdec_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the opdec testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module opdec_tb -o opdec_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/opdec_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
